// File: Bender.yml
package:
  name: rv_core

sources:
  - rtl/rv_pkg.sv
  - rtl/core_ifs.sv
  - rtl/fetch_stage.sv
  - rtl/decode_stage.sv
  - rtl/hazard_unit.sv
  - rtl/execute_stage.sv
  - rtl/mem_wb_stage.sv
  - rtl/rv_core.sv
  - target: test
    files:
      - tests/rv_core_chk.sv
      - tests/tb_rv_core.sv

// File: rtl/core_ifs.sv
// Stall and flush controls from the hazard unit
interface hazard_ctrl_if ();
    logic if_id_flush;
    logic if_id_en;
    logic id_ex_flush;
    logic pc_en;

    modport hazard (output if_id_flush, if_id_en, id_ex_flush, pc_en);
    modport fetch  (input pc_en, if_id_flush, if_id_en);
    modport decode (input id_ex_flush);
endinterface

interface id_ex_if import rv_pkg::*; ();
    logic     valid;
    addr_t    pc;
    alu_op_t  alu_op;
    opcode_t  opcode;
    reg_idx_t rd;
    reg_idx_t rs1;
    reg_idx_t rs2;
    word_t    rs1_val;
    word_t    rs2_val;
    word_t    imm;

    modport source (output valid, pc, alu_op, opcode, rd, rs1, rs2, rs1_val, rs2_val, imm);
    modport sink   (input valid, pc, alu_op, opcode, rd, rs1, rs2, rs1_val, rs2_val, imm);
    modport hazard (input rd, opcode);
endinterface

interface writeback_if import rv_pkg::*; ();
    logic     we;
    reg_idx_t rd;
    word_t    data;

    modport source  (output we, rd, data);
    modport sink    (input we, rd, data);
    modport forward (input we, rd, data);
endinterface

// File: rtl/decode_stage.sv
module decode_stage import rv_pkg::*; (
    input  logic          clk,
    input  logic          rst_n,
    hazard_ctrl_if.decode hz,
    input  word_t         if_id_instr,
    input  addr_t         if_id_pc,
    input  logic          if_id_valid,
    writeback_if.sink     wb,
    id_ex_if.source       ex,
    output reg_idx_t      id_rs1,
    output reg_idx_t      id_rs2,
    output opcode_t       id_opcode,
    output logic          invalid_inst
);

    instr_u   instr;
    word_t    regs [32];
    word_t    rs1_val;
    word_t    rs2_val;
    word_t    imm;
    alu_op_t  alu_op;
    reg_idx_t rd;
    logic     known_op;

    function automatic alu_op_t alu_decode(logic [2:0] funct3, logic sub);
        case (funct3)
            3'b000:  return sub ? ALU_SUB : ALU_ADD;
            3'b010:  return ALU_SLT;
            3'b100:  return ALU_XOR;
            3'b110:  return ALU_OR;
            3'b111:  return ALU_AND;
            default: return ALU_ADD;
        endcase
    endfunction

    assign instr     = if_id_instr;
    assign id_opcode = opcode_t'(instr.ri.opcode);
    assign id_rs1    = instr.ri.rs1;
    assign id_rs2    = instr.ri.rs2;

    // Write-first register file, x0 reads as zero
    assign rs1_val = (id_rs1 == '0) ? '0 : (wb.we && wb.rd == id_rs1) ? wb.data : regs[id_rs1];
    assign rs2_val = (id_rs2 == '0) ? '0 : (wb.we && wb.rd == id_rs2) ? wb.data : regs[id_rs2];

    always_ff @(posedge clk) begin
        if (wb.we && wb.rd != '0) regs[wb.rd] <= wb.data;
    end

    always_comb begin
        known_op = 1'b1;
        imm      = '0;
        alu_op   = ALU_ADD;
        rd       = instr.ri.rd;
        case (id_opcode)
            OP_RTYPE: alu_op = alu_decode(instr.ri.funct3, instr.ri.funct7[5]);
            OP_ITYPE: begin
                imm    = {{20{instr.ri.funct7[6]}}, instr.ri.funct7, instr.ri.rs2};
                alu_op = alu_decode(instr.ri.funct3, 1'b0);
            end
            OP_ILOAD, OP_IJALR: imm = {{20{instr.ri.funct7[6]}}, instr.ri.funct7, instr.ri.rs2};
            OP_STYPE: begin
                imm = {{20{instr.sb.imm_hi[6]}}, instr.sb.imm_hi, instr.sb.imm_lo};
                rd  = '0;                    // The rd bits hold imm_lo here
            end
            OP_BTYPE: begin
                imm    = {{20{instr.sb.imm_hi[6]}}, instr.sb.imm_lo[0], instr.sb.imm_hi[5:0],
                          instr.sb.imm_lo[4:1], 1'b0};
                rd     = '0;
                alu_op = instr.sb.funct3[0] ? ALU_XOR : ALU_SUB;  // BNE : BEQ
            end
            OP_JAL: imm = {{12{instr.raw[31]}}, instr.raw[19:12], instr.raw[20],
                           instr.raw[30:21], 1'b0};
            default: begin
                known_op = 1'b0;
                rd       = '0;
            end
        endcase
    end

    assign invalid_inst = if_id_valid && !known_op;

    always_ff @(posedge clk) begin
        if (!rst_n || hz.id_ex_flush) begin
            ex.valid  <= 1'b0;               // Bubble carries rd 0 so nothing matches it
            ex.rd     <= '0;
            ex.opcode <= OP_ITYPE;
        end else begin
            ex.valid  <= if_id_valid;
            ex.rd     <= rd;
            ex.opcode <= id_opcode;
        end
        ex.pc      <= if_id_pc;
        ex.alu_op  <= alu_op;
        ex.rs1     <= id_rs1;
        ex.rs2     <= id_rs2;
        ex.rs1_val <= rs1_val;
        ex.rs2_val <= rs2_val;
        ex.imm     <= imm;
    end

endmodule

// File: rtl/execute_stage.sv
module execute_stage import rv_pkg::*; (
    input  logic          clk,
    input  logic          rst_n,
    id_ex_if.sink         ex,
    writeback_if.forward  wb,
    output logic          redirect_valid,
    output addr_t         redirect_pc,
    output logic          mem_valid,
    output logic          mem_is_load,
    output logic          mem_is_store,
    output reg_idx_t      mem_rd,
    output word_t         mem_result,
    output word_t         mem_store_data,
    output addr_t         mem_pc
);

    logic     ex_mem_we;
    reg_idx_t ex_mem_rd;
    word_t    ex_mem_data;
    word_t    rs1_fwd;
    word_t    rs2_fwd;
    word_t    op_b;
    word_t    alu_res;
    logic     is_jump;
    logic     taken;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Forwarding, newest value first
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign ex_mem_we   = mem_valid && !mem_is_load && mem_rd != '0;  // Load data arrives later
    assign ex_mem_rd   = mem_rd;
    assign ex_mem_data = mem_result;

    assign rs1_fwd = (ex_mem_we && ex_mem_rd == ex.rs1) ? ex_mem_data :
                     (wb.we && wb.rd == ex.rs1) ? wb.data : ex.rs1_val;
    assign rs2_fwd = (ex_mem_we && ex_mem_rd == ex.rs2) ? ex_mem_data :
                     (wb.we && wb.rd == ex.rs2) ? wb.data : ex.rs2_val;

    assign op_b = (ex.opcode == OP_RTYPE || ex.opcode == OP_BTYPE) ? rs2_fwd : ex.imm;

    always_comb begin
        case (ex.alu_op)
            ALU_SUB: alu_res = rs1_fwd - op_b;
            ALU_AND: alu_res = rs1_fwd & op_b;
            ALU_OR:  alu_res = rs1_fwd | op_b;
            ALU_XOR: alu_res = rs1_fwd ^ op_b;
            ALU_SLT: alu_res = {31'b0, $signed(rs1_fwd) < $signed(op_b)};
            default: alu_res = rs1_fwd + op_b;
        endcase
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Branch and jump resolution
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign is_jump = ex.opcode == OP_JAL || ex.opcode == OP_IJALR;
    // BEQ runs SUB and BNE runs XOR, both give zero on equal operands
    assign taken   = ex.opcode == OP_BTYPE && ((ex.alu_op == ALU_SUB) == (alu_res == '0));

    assign redirect_valid = ex.valid && (is_jump || taken);
    assign redirect_pc    = (ex.opcode == OP_IJALR) ? {alu_res[31:1], 1'b0} : ex.pc + ex.imm;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mem_valid    <= 1'b0;
            mem_is_load  <= 1'b0;
            mem_is_store <= 1'b0;
            mem_rd       <= '0;
        end else begin
            mem_valid    <= ex.valid;
            mem_is_load  <= ex.valid && ex.opcode == OP_ILOAD;
            mem_is_store <= ex.valid && ex.opcode == OP_STYPE;
            mem_rd       <= ex.valid ? ex.rd : '0;
        end
        mem_result     <= is_jump ? ex.pc + 32'd4 : alu_res;  // Link value for jumps
        mem_store_data <= rs2_fwd;
        mem_pc         <= ex.pc;
    end

endmodule

// File: rtl/fetch_stage.sv
module fetch_stage import rv_pkg::*; (
    input  logic          clk,
    input  logic          rst_n,
    hazard_ctrl_if.fetch  hz,
    input  logic          redirect_valid,
    input  addr_t         redirect_pc,
    output logic          ibus_cyc,
    output logic          ibus_stb,
    output addr_t         ibus_adr,
    input  word_t         ibus_dat_r,
    input  logic          ibus_ack,
    output logic          fetch_wait,
    output word_t         if_id_instr,
    output addr_t         if_id_pc,
    output logic          if_id_valid
);

    addr_t pc;                               // Address of the word being fetched or held
    addr_t pc_next;
    logic  req;                              // Wishbone cycle in progress
    logic  have;                             // Acked word parked until IF/ID takes it
    logic  have_next;
    word_t hold_instr;
    logic  discard;                          // Pending cycle belongs to a flushed path
    logic  bus_done;
    logic  ack_ok;
    logic  word_avail;
    logic  take;
    logic  issue;

    assign ibus_cyc   = req;
    assign ibus_stb   = req;
    assign bus_done   = req && ibus_ack;
    assign ack_ok     = bus_done && !discard;
    assign word_avail = have || ack_ok;
    assign fetch_wait = !word_avail;         // Nothing usable for IF/ID this cycle
    assign take       = hz.if_id_en && word_avail;

    always_comb begin
        pc_next   = pc;
        have_next = have;
        if (hz.pc_en) begin
            if (redirect_valid) pc_next = redirect_pc;
            else if (take) pc_next = pc + 32'd4;
        end
        if (redirect_valid || take) have_next = 1'b0;
        else if (ack_ok) have_next = 1'b1;
    end

    // A new cycle starts once the bus is free and no word is waiting
    assign issue = (!req || bus_done) && !have_next;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc       <= '0;
            req      <= 1'b0;
            have     <= 1'b0;
            discard  <= 1'b0;
            ibus_adr <= '0;
        end else begin
            pc   <= pc_next;
            have <= have_next;
            req  <= (req && !bus_done) || issue;
            if (issue) ibus_adr <= pc_next;  // Address only moves between cycles
            if (req && !ibus_ack && redirect_valid) discard <= 1'b1;
            else if (bus_done) discard <= 1'b0;
        end
        if (ack_ok) hold_instr <= ibus_dat_r;
    end

    always_ff @(posedge clk) begin
        if (!rst_n || hz.if_id_flush) begin
            if_id_instr <= NOP_WORD;
            if_id_valid <= 1'b0;
        end else if (hz.if_id_en) begin
            if_id_instr <= !word_avail ? NOP_WORD : (have ? hold_instr : ibus_dat_r);
            if_id_valid <= word_avail;
            if_id_pc    <= pc;
        end
    end

endmodule

// File: rtl/hazard_unit.sv
module hazard_unit import rv_pkg::*; (
    input  reg_idx_t      id_rs1,
    input  reg_idx_t      id_rs2,
    input  opcode_t       id_opcode,
    id_ex_if.hazard       ex,
    input  logic          redirect_valid,
    input  logic          invalid_inst,
    input  logic          fetch_wait,
    hazard_ctrl_if.hazard hz
);

    logic     id_rs1_used;
    logic     id_rs2_used;
    reg_idx_t ex_rd;
    logic     ex_load_inst;
    logic     load_use;

    assign id_rs1_used = id_opcode inside {OP_RTYPE, OP_ITYPE, OP_ILOAD, OP_IJALR,
                                           OP_STYPE, OP_BTYPE};
    assign id_rs2_used = id_opcode inside {OP_RTYPE, OP_STYPE, OP_BTYPE};

    assign ex_rd        = ex.rd;
    assign ex_load_inst = (ex.opcode == OP_ILOAD);
    assign load_use     = ex_load_inst && ex_rd != '0 &&
                          ((id_rs1_used && id_rs1 == ex_rd) || (id_rs2_used && id_rs2 == ex_rd));

    always_comb begin
        hz.if_id_flush = 1'b0;
        hz.if_id_en    = 1'b1;
        hz.id_ex_flush = 1'b0;
        hz.pc_en       = 1'b1;
        if (redirect_valid) begin            // Two younger slots are dropped
            hz.if_id_flush = 1'b1;
            hz.if_id_en    = 1'b0;
            hz.id_ex_flush = 1'b1;
        end else if (load_use || (!invalid_inst && fetch_wait)) begin
            hz.if_id_en    = 1'b0;           // Hold IF and ID, bubble into EX
            hz.id_ex_flush = 1'b1;
            hz.pc_en       = 1'b0;
        end else if (invalid_inst) begin
            hz.id_ex_flush = 1'b1;
        end
    end

endmodule

// File: rtl/mem_wb_stage.sv
module mem_wb_stage import rv_pkg::*; #(
    parameter int DMEM_WORDS = 64
) (
    input  logic          clk,
    input  logic          rst_n,
    input  logic          mem_valid,
    input  logic          mem_is_load,
    input  logic          mem_is_store,
    input  reg_idx_t      mem_rd,
    input  word_t         mem_result,
    input  word_t         mem_store_data,
    input  addr_t         mem_pc,
    writeback_if.source   wb,
    output logic          retire_valid,
    output addr_t         retire_pc,
    output reg_idx_t      retire_rd,
    output word_t         retire_data
);

    localparam int IDX_W = $clog2(DMEM_WORDS);

    word_t             dmem [DMEM_WORDS];
    logic [IDX_W-1:0]  dmem_idx;
    logic              wb_valid;
    reg_idx_t          wb_rd;
    word_t             wb_data;
    addr_t             wb_pc;

    // Byte address to word index, wrapped onto the RAM
    assign dmem_idx = IDX_W'((mem_result >> 2) % DMEM_WORDS);

    always_ff @(posedge clk) begin
        if (mem_valid && mem_is_store) dmem[dmem_idx] <= mem_store_data;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wb_valid <= 1'b0;
            wb_rd    <= '0;
        end else begin
            wb_valid <= mem_valid;
            wb_rd    <= mem_rd;
        end
        if (mem_rd == '0) wb_data <= '0;     // Stores and x0 targets report zero
        else wb_data <= mem_is_load ? dmem[dmem_idx] : mem_result;
        wb_pc <= mem_pc;
    end

    assign wb.we   = wb_valid && wb_rd != '0;
    assign wb.rd   = wb_rd;
    assign wb.data = wb_data;

    assign retire_valid = wb_valid;
    assign retire_pc    = wb_pc;
    assign retire_rd    = wb_rd;
    assign retire_data  = wb_data;

endmodule

// File: rtl/rv_core.sv
module rv_core import rv_pkg::*; #(
    parameter int DMEM_WORDS = 64
) (
    input  logic     clk,
    input  logic     rst_n,
    output logic     ibus_cyc,
    output logic     ibus_stb,
    output addr_t    ibus_adr,
    input  word_t    ibus_dat_r,
    input  logic     ibus_ack,
    output logic     retire_valid,
    output addr_t    retire_pc,
    output reg_idx_t retire_rd,
    output word_t    retire_data
);

    logic     redirect_valid;
    addr_t    redirect_pc;
    logic     fetch_wait;
    word_t    if_id_instr;
    addr_t    if_id_pc;
    logic     if_id_valid;
    reg_idx_t id_rs1;
    reg_idx_t id_rs2;
    opcode_t  id_opcode;
    logic     invalid_inst;
    logic     mem_valid;
    logic     mem_is_load;
    logic     mem_is_store;
    reg_idx_t mem_rd;
    word_t    mem_result;
    word_t    mem_store_data;
    addr_t    mem_pc;

    hazard_ctrl_if hz_if ();
    id_ex_if       id_ex ();
    writeback_if   wb_if ();

    fetch_stage u_fetch (
        .clk, .rst_n, .hz(hz_if.fetch), .redirect_valid, .redirect_pc,
        .ibus_cyc, .ibus_stb, .ibus_adr, .ibus_dat_r, .ibus_ack,
        .fetch_wait, .if_id_instr, .if_id_pc, .if_id_valid
    );

    decode_stage u_decode (
        .clk, .rst_n, .hz(hz_if.decode), .if_id_instr, .if_id_pc, .if_id_valid,
        .wb(wb_if.sink), .ex(id_ex.source), .id_rs1, .id_rs2, .id_opcode, .invalid_inst
    );

    hazard_unit u_hazard (
        .id_rs1, .id_rs2, .id_opcode, .ex(id_ex.hazard),
        .redirect_valid, .invalid_inst, .fetch_wait, .hz(hz_if.hazard)
    );

    execute_stage u_execute (
        .clk, .rst_n, .ex(id_ex.sink), .wb(wb_if.forward), .redirect_valid, .redirect_pc,
        .mem_valid, .mem_is_load, .mem_is_store, .mem_rd, .mem_result, .mem_store_data,
        .mem_pc
    );

    mem_wb_stage #(.DMEM_WORDS(DMEM_WORDS)) u_mem_wb (
        .clk, .rst_n, .mem_valid, .mem_is_load, .mem_is_store, .mem_rd, .mem_result,
        .mem_store_data, .mem_pc, .wb(wb_if.source),
        .retire_valid, .retire_pc, .retire_rd, .retire_data
    );

endmodule

// File: rtl/rv_pkg.sv
package rv_pkg;

    typedef logic [31:0] word_t;
    typedef logic [31:0] addr_t;
    typedef logic [4:0]  reg_idx_t;

    // Base opcodes the core executes, anything else is turned into a bubble
    typedef enum logic [6:0] {
        OP_RTYPE = 7'b0110011,
        OP_ITYPE = 7'b0010011,
        OP_ILOAD = 7'b0000011,
        OP_IJALR = 7'b1100111,
        OP_STYPE = 7'b0100011,
        OP_BTYPE = 7'b1100011,
        OP_JAL   = 7'b1101111
    } opcode_t;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT
    } alu_op_t;

    typedef struct packed {
        logic [6:0] funct7;                  // Upper imm[11:5] for I-type
        reg_idx_t   rs2;                     // Lower imm[4:0] for I-type
        reg_idx_t   rs1;
        logic [2:0] funct3;
        reg_idx_t   rd;
        logic [6:0] opcode;
    } ri_view_t;

    typedef struct packed {
        logic [6:0] imm_hi;
        reg_idx_t   rs2;
        reg_idx_t   rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } sb_view_t;

    typedef union packed {
        word_t    raw;
        ri_view_t ri;
        sb_view_t sb;
    } instr_u;

    localparam word_t NOP_WORD = 32'h0000_0013;  // ADDI x0, x0, 0

endpackage

// File: sources.f
rtl/rv_pkg.sv
rtl/core_ifs.sv
rtl/fetch_stage.sv
rtl/decode_stage.sv
rtl/hazard_unit.sv
rtl/execute_stage.sv
rtl/mem_wb_stage.sv
rtl/rv_core.sv
tests/rv_core_chk.sv
tests/tb_rv_core.sv

// File: tests/rv_core_chk.sv
module rv_core_chk import rv_pkg::*; (
    input logic  clk,
    input logic  rst_n,
    input logic  ibus_cyc,
    input logic  ibus_stb,
    input logic  ibus_ack,
    input addr_t ibus_adr,
    input logic  if_id_flush,
    input logic  if_id_en,
    input logic  retire_valid
);
    timeunit 1ns;
    timeprecision 100ps;

    int unsigned violations = 0;

    stb_in_cyc: assert property (@(posedge clk) disable iff (!rst_n) ibus_stb |-> ibus_cyc)
        else begin
            violations++;
            $error("Wishbone stb asserted outside a cycle");
        end

    // A request keeps its address until the slave acks it
    adr_held: assert property (@(posedge clk) disable iff (!rst_n)
        ibus_stb && !ibus_ack |=> ibus_stb && $stable(ibus_adr))
        else begin
            violations++;
            $error("Wishbone address moved or stb dropped before ack");
        end

    flush_or_en: assert property (@(posedge clk) disable iff (!rst_n)
        !(if_id_flush && if_id_en))
        else begin
            violations++;
            $error("IF/ID flush and enable both set");
        end

    quiet_in_reset: assert property (@(posedge clk) !rst_n |=> !retire_valid)
        else begin
            violations++;
            $error("Retire port active under reset");
        end

endmodule

bind rv_core rv_core_chk u_chk (
    .clk, .rst_n, .ibus_cyc, .ibus_stb, .ibus_ack, .ibus_adr,
    .if_id_flush(hz_if.if_id_flush), .if_id_en(hz_if.if_id_en), .retire_valid
);

// File: tests/tb_rv_core.sv
module tb_rv_core import rv_pkg::*; ();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int CLK_PERIOD      = 40;
    localparam int PROG_LEN        = 96;
    localparam int DMEM_WORDS      = 64;
    localparam int WATCHDOG_CYCLES = (PROG_LEN * 4 + 40) * 5;

    typedef enum int {
        K_ADD, K_SUB, K_AND, K_OR, K_XOR, K_SLT,
        K_ADDI, K_ANDI, K_ORI, K_XORI, K_SLTI,
        K_LW, K_SW, K_BEQ, K_BNE, K_JAL, K_JALR, K_BAD
    } kind_e;

    logic     clk;
    logic     rst_n;
    logic     ibus_cyc;
    logic     ibus_stb;
    addr_t    ibus_adr;
    word_t    ibus_dat_r;
    logic     ibus_ack;
    logic     retire_valid;
    addr_t    retire_pc;
    reg_idx_t retire_rd;
    word_t    retire_data;

    integer   seed;
    kind_e    p_kind [PROG_LEN];
    reg_idx_t p_rd   [PROG_LEN];
    reg_idx_t p_rs1  [PROG_LEN];
    reg_idx_t p_rs2  [PROG_LEN];
    word_t    p_imm  [PROG_LEN];                 // Invalid slots keep their raw word here
    word_t    prog   [PROG_LEN];
    addr_t    exp_pc   [$];
    reg_idx_t exp_rd   [$];
    word_t    exp_data [$];

    rv_core #(.DMEM_WORDS(DMEM_WORDS)) DUT (
        .clk, .rst_n, .ibus_cyc, .ibus_stb, .ibus_adr, .ibus_dat_r, .ibus_ack,
        .retire_valid, .retire_pc, .retire_rd, .retire_data
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic abort_run(string why);
        $display("%s", why);
        $display("=== FAIL ===");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic check_pc(string name, addr_t expected, addr_t actual);
        if (actual !== expected)
            abort_run($sformatf("FAILED %s: expected %h, actual %h", name, expected, actual));
    endtask

    task automatic check_reg(string name, reg_idx_t expected, reg_idx_t actual);
        if (actual !== expected)
            abort_run($sformatf("FAILED %s: expected x%0d, actual x%0d", name, expected, actual));
    endtask

    task automatic check_word(string name, word_t expected, word_t actual);
        if (actual !== expected)
            abort_run($sformatf("FAILED %s: expected %h, actual %h", name, expected, actual));
    endtask

    function automatic int rnd(int n);
        return $unsigned($random(seed)) % n;
    endfunction

    function automatic reg_idx_t pick_reg();
        int n;
        n = rnd(10);
        if (n < 7) return reg_idx_t'(1 + rnd(4));  // Hot set x1..x4 provokes load-use
        else if (n < 9) return reg_idx_t'(5 + rnd(3));
        return '0;
    endfunction

    // One of eight data words, pushed past the RAM end by whole wraps, any byte offset
    function automatic word_t mem_offset();
        return word_t'(4 * rnd(8) + DMEM_WORDS * 4 * rnd(8) + rnd(4));
    endfunction

    function automatic word_t encode(int i);
        word_t    imm;
        reg_idx_t rd;
        reg_idx_t rs1;
        reg_idx_t rs2;
        imm = p_imm[i];
        rd  = p_rd[i];
        rs1 = p_rs1[i];
        rs2 = p_rs2[i];
        case (p_kind[i])
            K_ADD:  return {7'h00, rs2, rs1, 3'b000, rd, OP_RTYPE};
            K_SUB:  return {7'h20, rs2, rs1, 3'b000, rd, OP_RTYPE};
            K_AND:  return {7'h00, rs2, rs1, 3'b111, rd, OP_RTYPE};
            K_OR:   return {7'h00, rs2, rs1, 3'b110, rd, OP_RTYPE};
            K_XOR:  return {7'h00, rs2, rs1, 3'b100, rd, OP_RTYPE};
            K_SLT:  return {7'h00, rs2, rs1, 3'b010, rd, OP_RTYPE};
            K_ADDI: return {imm[11:0], rs1, 3'b000, rd, OP_ITYPE};
            K_ANDI: return {imm[11:0], rs1, 3'b111, rd, OP_ITYPE};
            K_ORI:  return {imm[11:0], rs1, 3'b110, rd, OP_ITYPE};
            K_XORI: return {imm[11:0], rs1, 3'b100, rd, OP_ITYPE};
            K_SLTI: return {imm[11:0], rs1, 3'b010, rd, OP_ITYPE};
            K_LW:   return {imm[11:0], rs1, 3'b010, rd, OP_ILOAD};
            K_SW:   return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], OP_STYPE};
            K_BEQ:  return {imm[12], imm[10:5], rs2, rs1, 3'b000, imm[4:1], imm[11], OP_BTYPE};
            K_BNE:  return {imm[12], imm[10:5], rs2, rs1, 3'b001, imm[4:1], imm[11], OP_BTYPE};
            K_JAL:  return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OP_JAL};
            K_JALR: return {imm[11:0], rs1, 3'b000, rd, OP_IJALR};
            default: return imm;
        endcase
    endfunction

    function automatic word_t alu_ref(kind_e k, word_t a, word_t b);
        case (k)
            K_SUB:         return a - b;
            K_AND, K_ANDI: return a & b;
            K_OR, K_ORI:   return a | b;
            K_XOR, K_XORI: return a ^ b;
            K_SLT, K_SLTI: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            default:       return a + b;
        endcase
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Program generation and instruction-level reference model
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic make_program();
        int pick;
        for (int i = 0; i < PROG_LEN; i++) begin
            p_rd[i]  = '0;
            p_rs1[i] = '0;
            p_rs2[i] = '0;
            p_imm[i] = '0;
            pick     = rnd(100);
            if (i < 7) begin                         // Prologue gives x1..x7 known values
                p_kind[i] = K_ADDI;
                p_rd[i]   = reg_idx_t'(i + 1);
                p_imm[i]  = word_t'(rnd(4096) - 2048);
            end else if (i < 15) begin               // Then fills the eight data words
                p_kind[i] = K_SW;
                p_rs2[i]  = reg_idx_t'(1 + (i - 7) % 7);
                p_imm[i]  = word_t'(4 * (i - 7));
            end else if (pick < 5) begin
                p_kind[i] = K_BAD;
                p_imm[i]  = $random(seed);
                while (p_imm[i][6:0] inside {OP_RTYPE, OP_ITYPE, OP_ILOAD, OP_IJALR,
                                             OP_STYPE, OP_BTYPE, OP_JAL})
                    p_imm[i][6:0] = 7'(rnd(128));
            end else if (pick < 30) begin
                p_kind[i] = kind_e'(K_ADD + rnd(6));
                p_rd[i]   = pick_reg();
                p_rs1[i]  = pick_reg();
                p_rs2[i]  = pick_reg();
            end else if (pick < 50) begin
                p_kind[i] = kind_e'(K_ADDI + rnd(5));
                p_rd[i]   = pick_reg();
                p_rs1[i]  = pick_reg();
                p_imm[i]  = word_t'(rnd(4096) - 2048);
            end else if (pick < 65) begin
                p_kind[i] = K_LW;
                p_rd[i]   = pick_reg();
                p_imm[i]  = mem_offset();
            end else if (pick < 75) begin
                p_kind[i] = K_SW;
                p_rs2[i]  = pick_reg();
                p_imm[i]  = mem_offset();
            end else if (pick < 87) begin
                p_kind[i] = kind_e'(K_BEQ + rnd(2));
                p_rs1[i]  = pick_reg();
                p_rs2[i]  = pick_reg();
                p_imm[i]  = word_t'(4 * (1 + rnd(4)));
            end else if (pick < 94) begin
                p_kind[i] = K_JAL;
                p_rd[i]   = pick_reg();
                p_imm[i]  = word_t'(4 * (1 + rnd(4)));
            end else begin
                p_kind[i] = K_JALR;                  // Absolute forward target from x0
                p_rd[i]   = pick_reg();
                p_imm[i]  = word_t'(4 * (i + 1 + rnd(4)));
            end
            prog[i] = encode(i);
        end
    endtask

    task automatic run_model();
        word_t regs [32];
        word_t dmem [DMEM_WORDS];
        addr_t pc;
        addr_t next;
        word_t a;
        word_t b;
        word_t res;
        int    i;
        int    idx;
        regs = '{default: '0};
        dmem = '{default: '0};
        pc   = '0;
        while (pc < PROG_LEN * 4) begin
            i    = pc >> 2;
            a    = regs[p_rs1[i]];
            b    = regs[p_rs2[i]];
            next = pc + 4;
            res  = '0;
            idx  = ((a + p_imm[i]) >> 2) % DMEM_WORDS;
            case (p_kind[i])
                K_ADD, K_SUB, K_AND, K_OR, K_XOR, K_SLT: res = alu_ref(p_kind[i], a, b);
                K_LW:   res = dmem[idx];
                K_SW:   dmem[idx] = b;
                K_BEQ:  if (a == b) next = pc + p_imm[i];
                K_BNE:  if (a != b) next = pc + p_imm[i];
                K_JAL: begin
                    res  = pc + 4;
                    next = pc + p_imm[i];
                end
                K_JALR: begin
                    res  = pc + 4;
                    next = (a + p_imm[i]) & ~32'd1;
                end
                K_BAD: ;
                default: res = alu_ref(p_kind[i], a, p_imm[i]);
            endcase
            if (p_kind[i] != K_BAD) begin
                exp_pc.push_back(pc);
                exp_rd.push_back(p_rd[i]);
                exp_data.push_back(p_rd[i] == '0 ? '0 : res);
                if (p_rd[i] != '0) regs[p_rd[i]] = res;
            end
            pc = next;
        end
    endtask

    function automatic word_t fetch_word(addr_t adr);
        if ((adr >> 2) < PROG_LEN) return prog[adr >> 2];
        return NOP_WORD;                             // Past the end the core runs on NOPs
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Wishbone slave with 0 to 3 wait states per read
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    initial begin
        int   wait_left;
        logic busy;
        logic first_req;
        wait_left = 0;
        busy      = 1'b0;
        first_req = 1'b1;
        forever begin
            @(negedge clk);
            ibus_ack = 1'b0;
            if (rst_n && ibus_cyc && ibus_stb) begin
                if (first_req) check_pc("first fetch address", '0, ibus_adr);
                first_req = 1'b0;
                if (!busy) begin
                    busy      = 1'b1;
                    wait_left = rnd(4);
                end
                if (wait_left == 0) begin
                    ibus_ack   = 1'b1;
                    ibus_dat_r = fetch_word(ibus_adr);
                    busy       = 1'b0;
                end else begin
                    wait_left--;
                end
            end
        end
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        abort_run($sformatf("Timeout: retirements incomplete after %0d cycles",
                            WATCHDOG_CYCLES));
    end

    initial begin
        int    n_ret;
        kind_e k;
        string name;
        rst_n      = 1'b0;
        ibus_ack   = 1'b0;
        ibus_dat_r = '0;
        seed       = 32'hbc2f21aa;
        make_program();
        run_model();
        repeat (10) begin
            @(negedge clk);
            if (retire_valid !== 1'b0) abort_run("retire_valid is not low during reset");
        end
        rst_n = 1'b1;
        n_ret = 0;
        while (n_ret < exp_pc.size()) begin
            @(negedge clk);
            if (retire_valid === 1'b1) begin
                k    = p_kind[exp_pc[n_ret] >> 2];
                name = $sformatf("retire %0d %s at %h", n_ret, k.name(), exp_pc[n_ret]);
                check_pc({name, " pc"}, exp_pc[n_ret], retire_pc);
                check_reg({name, " rd"}, exp_rd[n_ret], retire_rd);
                check_word({name, " data"}, exp_data[n_ret], retire_data);
                n_ret++;
            end else if (retire_valid !== 1'b0) begin
                abort_run("retire_valid is unknown after reset");
            end
        end
        if (DUT.u_chk.violations == 0) begin
            $display("=== PASS ===");
            $finish;
        end else begin
            abort_run("The bus and hazard checker flagged a violation");
        end
    end

endmodule
